/* list.f */
hdl/mem_access_pkg.sv
hdl/uncached_access.sv
hdl/line_cache.sv
hdl/io_bus_arbiter.sv
hdl/access_router.sv
hdl/mem_access_top.sv
tb/io_slave_model.sv
tb/tb_mem_access.sv

/* Makefile */
# Verilator build and run of the memory access unit testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_access
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 --Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_mem_access.sv */
// random test of the memory access unit against a byte-array model
// cached window 0x0 to 0x7ff, uncached window 256 bytes at UNC_BASE
`timescale 1ns/1ps
`default_nettype none

module tb_mem_access;

  localparam logic [63:0] UNC_BASE = 64'h0000_0000_8000_0000;
  localparam int          TIMEOUT  = 200; // cycles per access

  logic                     clk;
  logic                     rst;
  logic                     req;
  mem_access_pkg::cpu_req_t cpu_req;
  logic                     ack;
  logic [63:0]              rdata;
  logic                     io_valid;
  mem_access_pkg::io_req_t  io_req;
  logic                     io_ready;
  mem_access_pkg::io_word_t io_rdata;
  logic                     stall;
  logic [31:0]              rng_state;
  logic [31:0]              stall_rng;
  logic [7:0]               ref_mem [4096];
  logic                     timed_out;
  int                       errors;
  int                       tests_run;
  int                       tests_failed;
  int                       ack_count;
  int                       xfer_count;
  int                       stall_count;
  logic [2:0]               last_size;
  logic [7:0]               last_blks;
  logic [63:0]              last_addr;
  logic                     held;
  mem_access_pkg::io_req_t  held_req;

  mem_access_top #(
    .UNCACHED_BASE (UNC_BASE),
    .LINE_COUNT    (8)
  ) dut0 (
    .clk        (clk),
    .rst        (rst),
    .i_req      (req),
    .i_cpu_req  (cpu_req),
    .o_ack      (ack),
    .o_rdata    (rdata),
    .o_io_valid (io_valid),
    .o_io_req   (io_req),
    .i_io_ready (io_ready),
    .i_io_rdata (io_rdata)
  );

  io_slave_model slv0 (
    .clk        (clk),
    .i_stall    (stall),
    .i_io_valid (io_valid),
    .i_io_req   (io_req),
    .o_io_ready (io_ready),
    .o_io_rdata (io_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // bytes moved are 2, 4 or 8 when asked and one byte otherwise
  function automatic int eff_bytes(input logic [2:0] bytes);
    int n;
    n = int'(bytes) + 1;
    if (n == 2 || n == 4 || n == 8) begin
      return n;
    end
    return 1;
  endfunction

  function automatic logic [2:0] expected_size(input logic [2:0] bytes);
    int s;
    s = 0;
    while ((1 << s) < eff_bytes(bytes)) begin
      s++;
    end
    return 3'(s);
  endfunction

  function automatic int model_index(input logic [63:0] a);
    return int'({a[31], a[10:0]});
  endfunction

  function automatic logic [63:0] model_read(input logic [63:0] a, input logic [2:0] bytes);
    logic [63:0] d;
    d = '0;
    for (int i = 0; i < eff_bytes(bytes); i++) begin
      d[8*i +: 8] = ref_mem[model_index(a + 64'(i))];
    end
    return d;
  endfunction

  function automatic logic [63:0] rand_addr(input logic unc, input logic [2:0] bytes);
    logic [63:0] a;
    if (unc) begin
      a = UNC_BASE + 64'(next_rand() & 32'hff);
    end else begin
      a = 64'(next_rand() & 32'h7ff);
    end
    return a & ~64'(eff_bytes(bytes) - 1); // natural alignment
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // random ready stalls from their own stream so stimulus order stays fixed
  always @(posedge clk) begin
    stall_rng <= xorshift32(stall_rng);
    stall     <= stall_rng[0];
  end

  // bus monitor sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (ack) ack_count++;
      if (held) begin
        check_value("o_io_valid", 64'd1, 64'(io_valid));
        check_value("o_io_req.op", 64'(held_req.op), 64'(io_req.op));
        check_value("o_io_req.addr", held_req.addr, io_req.addr);
        check_value("o_io_req.size", 64'(held_req.size), 64'(io_req.size));
        check_value("o_io_req.wdata", held_req.wdata.dw[0], io_req.wdata.dw[0]);
      end
      held     = io_valid && !io_ready;
      held_req = io_req;
      if (held) stall_count++;
      if (io_valid && io_ready) begin
        xfer_count++;
        last_size = io_req.size;
        last_blks = io_req.blks;
        last_addr = io_req.addr;
      end
    end
  end

  task automatic do_access(input logic op, input logic [63:0] addr, input logic [2:0] bytes,
                           input logic [63:0] wdata, output logic [63:0] data);
    mem_access_pkg::cpu_req_t r;
    int                       cycles;
    data    = '0;
    r.addr  = addr;
    r.wdata = wdata;
    r.bytes = bytes;
    r.op    = op;
    @(posedge clk);
    ack_count  = 0;
    xfer_count = 0;
    req     <= 1'b1;
    cpu_req <= r;
    cycles  = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!ack && cycles < TIMEOUT);
    if (!ack) begin
      $display("timeout: no ack within %0d cycles for access at %h", TIMEOUT, addr);
      timed_out = 1'b1;
      return;
    end
    data = rdata;
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    @(posedge clk); // monitor has counted the cycle after the ack
    check_value("o_ack pulses", 64'd1, 64'(ack_count));
  endtask

  task automatic checked_access(input logic op, input logic [63:0] addr, input logic [2:0] bytes);
    logic [63:0] wdata;
    logic [63:0] data;
    logic [63:0] mask;
    wdata = {next_rand(), next_rand()};
    mask  = (eff_bytes(bytes) == 8) ? '1 : (64'd1 << (8 * eff_bytes(bytes))) - 64'd1;
    do_access(op, addr, bytes, wdata, data);
    if (timed_out) return;
    if (op) begin
      for (int i = 0; i < eff_bytes(bytes); i++) begin
        ref_mem[model_index(addr + 64'(i))] = wdata[8*i +: 8];
      end
    end else begin
      check_value("o_rdata", model_read(addr, bytes) & mask, data & mask);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (timed_out || errors != errs_before) begin
      tests_failed++;
      $display("test %s failed", name);
    end else begin
      $display("test %s ok", name);
    end
  endtask

  task automatic uncached_rw_seq();
    logic [2:0]  b;
    logic [63:0] a;
    for (int n = 0; n < 8; n++) begin
      b = 3'(next_rand());
      a = rand_addr(1'b1, b);
      checked_access(1'b1, a, b);
      if (timed_out) return;
      checked_access(1'b0, a, b);
      if (timed_out) return;
    end
  endtask

  task automatic miss_then_hit();
    checked_access(1'b0, 64'h1a8, 3'd7); // first cached access misses
    if (timed_out) return;
    check_value("fetch count", 64'd1, 64'(xfer_count));
    check_value("o_io_req.size", 64'(mem_access_pkg::SIZE_LINE), 64'(last_size));
    check_value("o_io_req.blks", 64'd0, 64'(last_blks));
    check_value("o_io_req.addr", 64'h180, last_addr); // 64 byte line holding 0x1a8
    checked_access(1'b0, 64'h180, 3'd7);
    if (timed_out) return;
    check_value("hit bus count", 64'd0, 64'(xfer_count));
  endtask

  task automatic write_through_seq();
    int idx;
    checked_access(1'b1, 64'h1b4, 3'd3);
    if (timed_out) return;
    checked_access(1'b0, 64'h1b4, 3'd3);
    if (timed_out) return;
    check_value("hit bus count", 64'd0, 64'(xfer_count));
    for (int i = 0; i < 4; i++) begin
      idx = model_index(64'h1b4 + 64'(i));
      check_value("slv0.mem", 64'(ref_mem[idx]), 64'(slv0.mem[idx]));
    end
  endtask

  task automatic size_code_sweep();
    for (int b = 0; b < 8; b++) begin
      checked_access(1'b0, rand_addr(1'b1, 3'(b)), 3'(b));
      if (timed_out) return;
      check_value("transfer count", 64'd1, 64'(xfer_count));
      check_value("o_io_req.size", 64'(expected_size(3'(b))), 64'(last_size));
    end
  endtask

  task automatic stalled_traffic();
    logic [31:0] r;
    stall_count = 0;
    for (int n = 0; n < 40; n++) begin
      r = next_rand();
      checked_access(r[0], rand_addr(r[1], r[4:2]), r[4:2]);
      if (timed_out) return;
    end
    if (stall_count == 0) begin
      $display("back-pressure test never saw a stalled transfer");
      errors++;
    end
  endtask

  task automatic random_mix();
    logic [31:0] r;
    for (int n = 0; n < 300; n++) begin
      r = next_rand();
      checked_access(r[0], rand_addr(r[1], r[4:2]), r[4:2]);
      if (timed_out) return;
    end
  endtask

  task automatic run_tests();
    int e;
    e = errors;
    uncached_rw_seq();
    report_test("uncached read after write", e);
    if (timed_out) return;
    e = errors;
    miss_then_hit();
    report_test("cached miss then hit", e);
    if (timed_out) return;
    e = errors;
    write_through_seq();
    report_test("write-through", e);
    if (timed_out) return;
    e = errors;
    size_code_sweep();
    report_test("size encoding", e);
    if (timed_out) return;
    e = errors;
    stalled_traffic();
    report_test("back-pressure", e);
    if (timed_out) return;
    e = errors;
    random_mix();
    report_test("random mix", e);
  endtask

  initial begin
    rst          = 1'b1;
    req          = 1'b0;
    cpu_req      = '0;
    stall        = 1'b0;
    rng_state    = 32'h0322745c;
    stall_rng    = 32'h0322745c;
    timed_out    = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    ack_count    = 0;
    xfer_count   = 0;
    stall_count  = 0;
    held         = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 4096; i++) begin
      ref_mem[i] = slv0.mem[i]; // model starts from the slave's fill
    end
    run_tests();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/io_slave_model.sv */
// byte-addressed memory on the I/O bus with ready low while i_stall is high
// decodes only addr[31] and addr[10:0], so accesses must stay in those windows
`timescale 1ns/1ps
`default_nettype none

module io_slave_model (
  input  wire                           clk,
  input  wire                           i_stall,
  input  wire                           i_io_valid,
  input  wire mem_access_pkg::io_req_t  i_io_req,
  output logic                          o_io_ready,
  output mem_access_pkg::io_word_t      o_io_rdata
);

  logic [7:0]  mem [4096];
  logic [11:0] base;
  int          nbytes;

  assign o_io_ready = !i_stall;
  assign base       = {i_io_req.addr[31], i_io_req.addr[10:0]};
  assign nbytes     = 1 << i_io_req.size;

  // fill from a hash of the full address
  initial begin
    logic [63:0] a;
    for (int i = 0; i < 4096; i++) begin
      a      = {32'd0, i[11], 20'd0, i[10:0]};
      mem[i] = 8'((a * 64'h9e37_79b9_7f4a_7c15) >> 56);
    end
  end

  // read data right-aligned with upper bytes zero
  always_comb begin
    o_io_rdata = '0;
    for (int i = 0; i < 64; i++) begin
      if (i < nbytes) begin
        o_io_rdata.line[8*i +: 8] = mem[12'(base + 12'(i))];
      end
    end
  end

  always @(posedge clk) begin
    if (i_io_valid && o_io_ready && i_io_req.op) begin
      for (int i = 0; i < 64; i++) begin
        if (i < nbytes) begin
          mem[12'(base + 12'(i))] <= i_io_req.wdata.line[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_access_top.sv */
// memory access unit with cached space below UNCACHED_BASE and uncached above
// LINE_COUNT must be a power of two, at least 2
`timescale 1ns/1ps
`default_nettype none

module mem_access_top #(
  parameter logic [63:0] UNCACHED_BASE = 64'h0000_0000_8000_0000,
  parameter int          LINE_COUNT    = 8
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_req,
  input  wire mem_access_pkg::cpu_req_t i_cpu_req,
  output logic                      o_ack,
  output logic [63:0]               o_rdata,
  output logic                      o_io_valid,
  output mem_access_pkg::io_req_t   o_io_req,
  input  wire                       i_io_ready,
  input  wire mem_access_pkg::io_word_t i_io_rdata
);

  mem_access_pkg::cpu_req_t path_req;
  logic                     cache_req;
  logic                     unc_req;
  logic                     cache_ack;
  logic                     unc_ack;
  logic [63:0]              cache_rdata;
  logic [63:0]              unc_rdata;
  logic                     cache_valid;
  logic                     unc_valid;
  logic                     cache_ready;
  logic                     unc_ready;
  mem_access_pkg::io_req_t  cache_io_req;
  mem_access_pkg::io_req_t  unc_io_req;

  access_router #(
    .UNCACHED_BASE (UNCACHED_BASE)
  ) router0 (
    .clk           (clk),
    .rst           (rst),
    .i_req         (i_req),
    .i_cpu_req     (i_cpu_req),
    .i_cache_ack   (cache_ack),
    .i_cache_rdata (cache_rdata),
    .i_unc_ack     (unc_ack),
    .i_unc_rdata   (unc_rdata),
    .o_cache_req   (cache_req),
    .o_unc_req     (unc_req),
    .o_cpu_req     (path_req),
    .o_ack         (o_ack),
    .o_rdata       (o_rdata)
  );

  line_cache #(
    .LINE_COUNT (LINE_COUNT)
  ) cache0 (
    .clk        (clk),
    .rst        (rst),
    .i_req      (cache_req),
    .i_cpu_req  (path_req),
    .i_io_ready (cache_ready),
    .i_io_rdata (i_io_rdata),
    .o_rdata    (cache_rdata),
    .o_ack      (cache_ack),
    .o_io_valid (cache_valid),
    .o_io_req   (cache_io_req)
  );

  uncached_access unc0 (
    .clk        (clk),
    .rst        (rst),
    .i_req      (unc_req),
    .i_cpu_req  (path_req),
    .i_io_ready (unc_ready),
    .i_io_rdata (i_io_rdata),
    .o_rdata    (unc_rdata),
    .o_ack      (unc_ack),
    .o_io_valid (unc_valid),
    .o_io_req   (unc_io_req)
  );

  io_bus_arbiter arb0 (
    .clk           (clk),
    .rst           (rst),
    .i_cache_valid (cache_valid),
    .i_cache_req   (cache_io_req),
    .i_unc_valid   (unc_valid),
    .i_unc_req     (unc_io_req),
    .i_io_ready    (i_io_ready),
    .o_cache_ready (cache_ready),
    .o_unc_ready   (unc_ready),
    .o_io_valid    (o_io_valid),
    .o_io_req      (o_io_req)
  );

endmodule

`default_nettype wire

/* hdl/access_router.sv */
// splits requests by address at UNCACHED_BASE and merges the responses
// the route stays fixed from the start of a request until its ack
`timescale 1ns/1ps
`default_nettype none

module access_router #(
  parameter logic [63:0] UNCACHED_BASE = 64'h0000_0000_8000_0000
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_req,
  input  wire mem_access_pkg::cpu_req_t i_cpu_req,
  input  wire                       i_cache_ack,
  input  wire [63:0]                i_cache_rdata,
  input  wire                       i_unc_ack,
  input  wire [63:0]                i_unc_rdata,
  output logic                      o_cache_req,
  output logic                      o_unc_req,
  output mem_access_pkg::cpu_req_t  o_cpu_req,
  output logic                      o_ack,
  output logic [63:0]               o_rdata
);

  logic busy_q;  // request outstanding
  logic route_q; // 1 when the latched path is uncached
  logic route_unc;

  assign route_unc = busy_q ? route_q : (i_cpu_req.addr >= UNCACHED_BASE);

  assign o_cache_req = i_req && !route_unc;
  assign o_unc_req   = i_req && route_unc;
  assign o_cpu_req   = i_cpu_req; // both paths see the same fields
  assign o_ack       = route_unc ? i_unc_ack : i_cache_ack;
  assign o_rdata     = route_unc ? i_unc_rdata : i_cache_rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      route_q <= 1'b0;
    end else if (o_ack) begin
      busy_q <= 1'b0;
    end else if (i_req && !busy_q) begin
      busy_q  <= 1'b1;
      route_q <= route_unc;
    end
  end

endmodule

`default_nettype wire

/* hdl/io_bus_arbiter.sv */
// fixed priority, cache first; grant held from first valid to handshake
`timescale 1ns/1ps
`default_nettype none

module io_bus_arbiter (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        i_cache_valid,
  input  wire mem_access_pkg::io_req_t i_cache_req,
  input  wire                        i_unc_valid,
  input  wire mem_access_pkg::io_req_t i_unc_req,
  input  wire                        i_io_ready,
  output logic                       o_cache_ready,
  output logic                       o_unc_ready,
  output logic                       o_io_valid,
  output mem_access_pkg::io_req_t    o_io_req
);

  logic lock_q;  // grant held
  logic owner_q; // 1 when the uncached path holds the lock
  logic sel_unc;
  logic hs;

  // free bus goes to the cache when it asks
  assign sel_unc = lock_q ? owner_q : !i_cache_valid;

  assign o_io_valid    = sel_unc ? i_unc_valid : i_cache_valid;
  assign o_io_req      = sel_unc ? i_unc_req : i_cache_req;
  assign o_cache_ready = !sel_unc && i_io_ready;
  assign o_unc_ready   = sel_unc && i_io_ready;
  assign hs            = o_io_valid && i_io_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      lock_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (hs) begin
      lock_q <= 1'b0; // release after the handshake
    end else if (o_io_valid && !lock_q) begin
      lock_q  <= 1'b1;
      owner_q <= sel_unc;
    end
  end

endmodule

`default_nettype wire

/* hdl/line_cache.sv */
// direct-mapped, read-allocate, write-through cache of 64 byte lines
// LINE_COUNT must be a power of two, at least 2; accesses naturally aligned
`timescale 1ns/1ps
`default_nettype none

module line_cache #(
  parameter int LINE_COUNT = 8
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_req,
  input  wire mem_access_pkg::cpu_req_t i_cpu_req,
  input  wire                       i_io_ready,
  input  wire mem_access_pkg::io_word_t i_io_rdata,
  output logic [63:0]               o_rdata,
  output logic                      o_ack,
  output logic                      o_io_valid,
  output mem_access_pkg::io_req_t   o_io_req
);

  localparam int IDX_W = $clog2(LINE_COUNT);
  localparam int TAG_W = 64 - 6 - IDX_W;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH, // line fill on the bus
    ST_WRITE, // write-through on the bus
    ST_RESP   // ack cycle
  } state_t;

  state_t                   state_q;
  logic [LINE_COUNT-1:0]    valid_q;
  logic [TAG_W-1:0]         tags [LINE_COUNT];
  mem_access_pkg::io_word_t lines [LINE_COUNT];

  logic [IDX_W-1:0]         idx;
  logic [TAG_W-1:0]         tag;
  logic [5:0]               off;
  logic                     hit;
  logic                     hs;
  logic                     start;
  logic                     fill;
  logic                     wr_done;
  logic [2:0]               size;
  logic [3:0]               nbytes;
  mem_access_pkg::io_word_t rd_line;
  mem_access_pkg::io_word_t merged;
  logic [63:0]              rd_dw;
  logic [63:0]              rd_val;

  assign idx     = i_cpu_req.addr[6 +: IDX_W];
  assign tag     = i_cpu_req.addr[63 -: TAG_W];
  assign off     = i_cpu_req.addr[5:0];
  assign hit     = valid_q[idx] && (tags[idx] == tag);
  assign hs      = o_io_valid && i_io_ready;
  assign start   = (state_q == ST_IDLE) && i_req;
  assign fill    = (state_q == ST_FETCH) && hs;
  assign wr_done = (state_q == ST_WRITE) && hs;
  assign size    = mem_access_pkg::size_of_bytes(i_cpu_req.bytes);
  assign nbytes  = 4'd1 << size;

  // read path takes the incoming line during a fill
  assign rd_line = (state_q == ST_FETCH) ? i_io_rdata : lines[idx];
  assign rd_dw   = rd_line.dw[off[5:3]];
  assign rd_val  = rd_dw >> {off[2:0], 3'b000}; // first byte to bits 7:0

  // store data merged into the held line
  always_comb begin
    logic [5:0] pos;
    merged = lines[idx];
    pos    = off;
    for (int i = 0; i < 8; i++) begin
      if (i < nbytes) begin
        merged.line[8*pos +: 8] = i_cpu_req.wdata[8*i +: 8];
      end
      pos = pos + 6'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      valid_q    <= '0; // all lines invalid
      o_io_valid <= 1'b0;
      o_ack      <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_req) begin
            if (i_cpu_req.op) begin
              o_io_valid <= 1'b1;
              state_q    <= ST_WRITE;
            end else if (hit) begin
              o_ack   <= 1'b1;
              state_q <= ST_RESP;
            end else begin
              o_io_valid <= 1'b1;
              state_q    <= ST_FETCH;
            end
          end
        end
        ST_FETCH: begin
          if (hs) begin
            o_io_valid   <= 1'b0;
            valid_q[idx] <= 1'b1;
            o_ack        <= 1'b1;
            state_q      <= ST_RESP;
          end
        end
        ST_WRITE: begin
          if (hs) begin
            o_io_valid <= 1'b0;
            o_ack      <= 1'b1;
            state_q    <= ST_RESP;
          end
        end
        ST_RESP: begin
          o_ack   <= 1'b0;
          state_q <= ST_IDLE; // next request is taken a cycle later
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // bus request fields, line storage and read data
  always_ff @(posedge clk) begin
    if (start) begin
      o_io_req.op         <= i_cpu_req.op;
      o_io_req.blks       <= 8'd0;
      o_io_req.wdata.line <= 512'(i_cpu_req.wdata);
      if (i_cpu_req.op) begin
        o_io_req.addr <= i_cpu_req.addr;
        o_io_req.size <= size;
      end else begin
        o_io_req.addr <= {i_cpu_req.addr[63:6], 6'b000000}; // line aligned
        o_io_req.size <= mem_access_pkg::SIZE_LINE;
      end
    end
    if ((start && !i_cpu_req.op && hit) || fill) begin
      o_rdata <= rd_val;
    end
    if (fill) begin
      lines[idx] <= i_io_rdata;
      tags[idx]  <= tag;
    end
    if (wr_done && hit) begin
      lines[idx] <= merged; // write hit updates with the ack
    end
  end

endmodule

`default_nettype wire

/* hdl/uncached_access.sv */
// one core request becomes one single-beat I/O bus transfer
// one request at a time; a request held high right after ack waits a cycle
`timescale 1ns/1ps
`default_nettype none

module uncached_access (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_req,
  input  wire mem_access_pkg::cpu_req_t i_cpu_req,
  input  wire                       i_io_ready,
  input  wire mem_access_pkg::io_word_t i_io_rdata,
  output logic [63:0]               o_rdata,
  output logic                      o_ack,
  output logic                      o_io_valid,
  output mem_access_pkg::io_req_t   o_io_req
);

  logic hs;    // bus handshake
  logic start; // new request while the bus is idle

  assign hs    = o_io_valid && i_io_ready;
  assign start = i_req && !o_ack && !o_io_valid;

  // valid and ack sequencing
  always_ff @(posedge clk) begin
    if (rst) begin
      o_io_valid <= 1'b0;
      o_ack      <= 1'b0;
    end else begin
      o_ack <= 1'b0; // ack is a single pulse
      if (start) begin
        o_io_valid <= 1'b1;
      end else if (hs) begin
        o_io_valid <= 1'b0;
        o_ack      <= 1'b1;
      end
    end
  end

  // request fields are loaded once and held through any stall
  always_ff @(posedge clk) begin
    if (start) begin
      o_io_req.op         <= i_cpu_req.op;
      o_io_req.addr       <= i_cpu_req.addr;
      o_io_req.size       <= mem_access_pkg::size_of_bytes(i_cpu_req.bytes);
      o_io_req.blks       <= 8'd0;
      o_io_req.wdata.line <= 512'(i_cpu_req.wdata); // low doubleword only
    end
    if (hs) begin
      o_rdata <= i_io_rdata.dw[0]; // slave returns data right-aligned
    end
  end

endmodule

`default_nettype wire

/* hdl/mem_access_pkg.sv */
// shared types for the memory access unit
// one-beat I/O bus transfers only, so blks is always zero
`default_nettype none

package mem_access_pkg;

  // AXI style size codes as log2 of the byte count
  localparam logic [2:0] SIZE_B    = 3'b000;
  localparam logic [2:0] SIZE_H    = 3'b001;
  localparam logic [2:0] SIZE_W    = 3'b010;
  localparam logic [2:0] SIZE_D    = 3'b011;
  localparam logic [2:0] SIZE_LINE = 3'b110; // 64 byte line

  typedef struct packed {
    logic [63:0] addr;
    logic [63:0] wdata; // right-aligned
    logic [2:0]  bytes; // byte count minus one
    logic        op;    // 0 read, 1 write
  } cpu_req_t;

  // whole line for the cache, low doubleword for the uncached path
  typedef union packed {
    logic [511:0]      line;
    logic [7:0][63:0]  dw;
  } io_word_t;

  typedef struct packed {
    logic        op;
    logic [63:0] addr;
    logic [2:0]  size;
    logic [7:0]  blks;
    io_word_t    wdata;
  } io_req_t;

  // unsupported counts fall back to a single byte
  function automatic logic [2:0] size_of_bytes(input logic [2:0] bytes);
    case (bytes)
      3'd0:    return SIZE_B;
      3'd1:    return SIZE_H;
      3'd3:    return SIZE_W;
      3'd7:    return SIZE_D;
      default: return SIZE_B;
    endcase
  endfunction

endpackage

`default_nettype wire
